// File: common/ip_rx_pkg.sv
`default_nettype none

package ip_rx_pkg;

  localparam int STREAM_W = 2;  // RMII carries two bits per clock.

  // Symbol counts derived from the stream width.
  localparam int WORD_SYMS = 16 / STREAM_W;
  localparam int SYM_CNT_W = $clog2(WORD_SYMS);
  localparam int FIELD_CNT_W = $clog2(32 / STREAM_W);
  localparam int VER_FIELD_W = (STREAM_W > 4) ? 8 : 4;  // Byte-wide symbols hold version and IHL.

  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] ip_len_t;
  typedef logic [7:0]  ip_proto_t;
  typedef logic [15:0] cksum_t;
  typedef logic [1:0]  reg_addr_t;

  typedef struct packed {
    ip_proto_t  protocol;
    ipv4_addr_t src_ip;
    ipv4_addr_t dst_ip;
    ip_len_t    length;
  } ipv4_hdr_t;

  typedef struct packed {
    logic done;
    logic ok;
  } hdr_verdict_t;

  typedef enum logic [3:0] {
    VERSION, IHL, DSCP_ECN, LENGTH, IDENT, FLAGS, TTL,
    PROTOCOL, CKSUM, SRC, DST, DONE, REJECT
  } parse_state_t;

  localparam logic [3:0] IPV4_VERSION = 4'd4;
  localparam logic [3:0] IPV4_IHL = 4'd5;
  localparam logic [2:0] FLAGS_DF_ONLY = 3'b010;  // Reserved 0, DF 1, MF 0.

  localparam reg_addr_t REG_LOCAL_IP = 2'd0;
  localparam reg_addr_t REG_CTRL = 2'd1;
  localparam reg_addr_t REG_ACCEPT_CNT = 2'd2;
  localparam reg_addr_t REG_DROP_CNT = 2'd3;

  localparam ipv4_addr_t BCAST_ADDR = 32'hffff_ffff;

endpackage

`default_nettype wire

// File: ipv4_rx/ones_sum_check.sv
`timescale 1ns/1ns
`default_nettype none

module ones_sum_check
  import ip_rx_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                sum_clear,
  input  logic                sum_sym_valid,
  input  logic [STREAM_W-1:0] sum_sym,
  output cksum_t              cksum
);

  logic [15:0] word_q;
  logic [15:0] word_next;
  logic [SYM_CNT_W-1:0] sym_cnt;
  logic word_done;
  logic [16:0] acc;  // Carry out is folded back in on the next add.
  logic [15:0] folded;

  assign word_next = {word_q[15-STREAM_W:0], sum_sym};
  assign word_done = (sym_cnt == SYM_CNT_W'(WORD_SYMS - 1));

  always_ff @(posedge clk) begin
    if (rst || sum_clear) begin
      sym_cnt <= '0;
      acc <= '0;
    end else if (sum_sym_valid) begin
      if (word_done) begin
        sym_cnt <= '0;
        acc <= {1'b0, acc[15:0]} + acc[16] + word_next;
      end else begin
        sym_cnt <= sym_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sum_sym_valid)
      word_q <= word_next;
  end

  assign folded = acc[15:0] + 16'(acc[16]);
  assign cksum = ~folded;  // Zero for a good header.

endmodule

`default_nettype wire

// File: ipv4_rx/ipv4_header_parse.sv
`timescale 1ns/1ns
`default_nettype none

module ipv4_header_parse
  import ip_rx_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                axiiv,
  input  logic [STREAM_W-1:0] axiid,
  input  cksum_t              cksum,
  output logic                sum_sym_valid,
  output logic [STREAM_W-1:0] sum_sym,
  output logic                sum_clear,
  output ipv4_hdr_t           hdr,
  output hdr_verdict_t        verdict
);

  parse_state_t state, next_state;
  logic [FIELD_CNT_W-1:0] cnt;
  logic [15:0] chk;
  logic [15:0] chk_next;
  logic in_hdr;
  logic field_last;
  logic verdict_pend;

  // Width in bits of the field parsed in each state.
  function automatic int field_bits(parse_state_t s);
    case (s)
      VERSION:                 return VER_FIELD_W;
      IHL:                     return 4;
      DSCP_ECN, TTL, PROTOCOL: return 8;
      SRC, DST:                return 32;
      default:                 return 16;
    endcase
  endfunction

  assign in_hdr = (state != DONE) && (state != REJECT);
  assign chk_next = {chk[15-STREAM_W:0], axiid};
  assign field_last = (cnt == FIELD_CNT_W'(field_bits(state) / STREAM_W - 1));

  assign sum_sym_valid = axiiv && in_hdr;
  assign sum_sym = axiid;
  assign sum_clear = !axiiv;

  always_comb begin
    next_state = state;
    case (state)
      VERSION: begin
        if (VER_FIELD_W == 8)
          next_state = (chk_next[7:4] == IPV4_VERSION && chk_next[3:0] == IPV4_IHL) ?
                       DSCP_ECN : REJECT;
        else
          next_state = (chk_next[3:0] == IPV4_VERSION) ? IHL : REJECT;
      end
      IHL:      next_state = (chk_next[3:0] == IPV4_IHL) ? DSCP_ECN : REJECT;
      DSCP_ECN: next_state = LENGTH;
      LENGTH:   next_state = IDENT;
      IDENT:    next_state = FLAGS;
      FLAGS:    next_state = (chk_next[15:13] == FLAGS_DF_ONLY) ? TTL : REJECT;
      TTL:      next_state = PROTOCOL;
      PROTOCOL: next_state = CKSUM;
      CKSUM:    next_state = SRC;
      SRC:      next_state = DST;
      DST:      next_state = DONE;
      default:  next_state = state;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= VERSION;
      cnt <= '0;
      verdict_pend <= 1'b0;
    end else begin
      verdict_pend <= 1'b0;
      if (!axiiv) begin
        state <= VERSION;  // Frame gap restarts the walk.
        cnt <= '0;
      end else if (in_hdr) begin
        if (field_last) begin
          cnt <= '0;
          state <= next_state;
          verdict_pend <= (next_state == DONE) || (next_state == REJECT);
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  // Field capture, MSB first.
  always_ff @(posedge clk) begin
    if (axiiv && in_hdr) begin
      chk <= chk_next;
      if (state == SRC)
        hdr.src_ip <= {hdr.src_ip[31-STREAM_W:0], axiid};
      if (state == DST)
        hdr.dst_ip <= {hdr.dst_ip[31-STREAM_W:0], axiid};
      if (field_last && state == LENGTH)
        hdr.length <= chk_next;
      if (field_last && state == PROTOCOL)
        hdr.protocol <= chk_next[7:0];
    end
  end

  assign verdict.done = verdict_pend;
  assign verdict.ok = verdict_pend && (state == DONE) && (cksum == '0);  // Sum is final here.

endmodule

`default_nettype wire

// File: source/ip_dest_filter.sv
`timescale 1ns/1ns
`default_nettype none

module ip_dest_filter
  import ip_rx_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  ipv4_hdr_t    hdr,
  input  hdr_verdict_t verdict,
  input  ipv4_addr_t   local_ip,
  input  logic         filter_en,
  input  logic         accept_bcast,
  output logic         pkt_valid,
  output ipv4_hdr_t    pkt_hdr,
  output logic         drop_pulse
);

  logic dest_ok;
  logic accept;

  assign dest_ok = !filter_en ||
                   (hdr.dst_ip == local_ip) ||
                   (accept_bcast && hdr.dst_ip == BCAST_ADDR);
  assign accept = verdict.ok && dest_ok;

  always_ff @(posedge clk) begin
    if (rst) begin
      pkt_valid <= 1'b0;
      drop_pulse <= 1'b0;
      pkt_hdr <= '0;
    end else begin
      pkt_valid <= verdict.done && accept;
      drop_pulse <= verdict.done && !accept;
      if (verdict.done && accept)
        pkt_hdr <= hdr;  // Held until the next accepted frame.
    end
  end

endmodule

`default_nettype wire

// File: source/ip_filter_regs.sv
`timescale 1ns/1ns
`default_nettype none

module ip_filter_regs
  import ip_rx_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        reg_we,
  input  reg_addr_t   reg_addr,
  input  logic [31:0] reg_wdata,
  output logic [31:0] reg_rdata,
  input  logic        pkt_valid,
  input  logic        drop_pulse,
  output ipv4_addr_t  local_ip,
  output logic        filter_en,
  output logic        accept_bcast
);

  logic [31:0] accept_cnt;
  logic [31:0] drop_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      local_ip <= '0;
      filter_en <= 1'b1;  // Filtering on out of reset.
      accept_bcast <= 1'b0;
      accept_cnt <= '0;
      drop_cnt <= '0;
    end else begin
      if (reg_we && reg_addr == REG_LOCAL_IP)
        local_ip <= reg_wdata;
      if (reg_we && reg_addr == REG_CTRL) begin
        filter_en <= reg_wdata[0];
        accept_bcast <= reg_wdata[1];
      end
      // A write to a counter clears it.
      if (reg_we && reg_addr == REG_ACCEPT_CNT)
        accept_cnt <= '0;
      else if (pkt_valid)
        accept_cnt <= accept_cnt + 1'b1;
      if (reg_we && reg_addr == REG_DROP_CNT)
        drop_cnt <= '0;
      else if (drop_pulse)
        drop_cnt <= drop_cnt + 1'b1;
    end
  end

  always_comb begin
    case (reg_addr)
      REG_LOCAL_IP:   reg_rdata = local_ip;
      REG_CTRL:       reg_rdata = {30'd0, accept_bcast, filter_en};
      REG_ACCEPT_CNT: reg_rdata = accept_cnt;
      default:        reg_rdata = drop_cnt;
    endcase
  end

endmodule

`default_nettype wire

// File: source/ip_rx_top.sv
`timescale 1ns/1ns
`default_nettype none

module ip_rx_top
  import ip_rx_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                axiiv,
  input  logic [STREAM_W-1:0] axiid,
  input  logic                reg_we,
  input  reg_addr_t           reg_addr,
  input  logic [31:0]         reg_wdata,
  output logic [31:0]         reg_rdata,
  output logic                pkt_valid,
  output ipv4_hdr_t           pkt_hdr
);

  logic sum_sym_valid;
  logic [STREAM_W-1:0] sum_sym;
  logic sum_clear;
  cksum_t cksum;
  ipv4_hdr_t hdr;
  hdr_verdict_t verdict;
  ipv4_addr_t local_ip;
  logic filter_en;
  logic accept_bcast;
  logic drop_pulse;

  ipv4_header_parse parse0 (
    .clk(clk), .rst(rst), .axiiv(axiiv), .axiid(axiid), .cksum(cksum),
    .sum_sym_valid(sum_sym_valid), .sum_sym(sum_sym), .sum_clear(sum_clear),
    .hdr(hdr), .verdict(verdict)
  );

  ones_sum_check sum0 (
    .clk(clk), .rst(rst), .sum_clear(sum_clear), .sum_sym_valid(sum_sym_valid),
    .sum_sym(sum_sym), .cksum(cksum)
  );

  ip_dest_filter filter0 (
    .clk(clk), .rst(rst), .hdr(hdr), .verdict(verdict), .local_ip(local_ip),
    .filter_en(filter_en), .accept_bcast(accept_bcast),
    .pkt_valid(pkt_valid), .pkt_hdr(pkt_hdr), .drop_pulse(drop_pulse)
  );

  ip_filter_regs regs0 (
    .clk(clk), .rst(rst), .reg_we(reg_we), .reg_addr(reg_addr),
    .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
    .pkt_valid(pkt_valid), .drop_pulse(drop_pulse),
    .local_ip(local_ip), .filter_en(filter_en), .accept_bcast(accept_bcast)
  );

endmodule

`default_nettype wire

// File: tb/ip_rx_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module ip_rx_asserts
  import ip_rx_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      reg_we,
  input reg_addr_t reg_addr,
  input logic      pkt_valid
);

  int fail_cnt = 0;  // Summed into the testbench verdict.

  // Accept is a single-cycle pulse.
  a_pulse_once: assert property (@(posedge clk) disable iff (rst) pkt_valid |=> !pkt_valid)
    else begin
      $error("pkt_valid held high for two cycles");
      fail_cnt++;
    end

  a_reset_quiet: assert property (@(posedge clk) rst |=> !pkt_valid)
    else begin
      $error("pkt_valid high during reset");
      fail_cnt++;
    end

  // Counter clears never collide with an accept.
  a_no_clear_clash: assert property (@(posedge clk) disable iff (rst)
      (reg_we && (reg_addr == REG_ACCEPT_CNT || reg_addr == REG_DROP_CNT)) |-> !pkt_valid)
    else begin
      $error("pkt_valid high during a counter write");
      fail_cnt++;
    end

endmodule

bind ip_rx_top ip_rx_asserts asserts0 (
  .clk(clk), .rst(rst), .reg_we(reg_we), .reg_addr(reg_addr), .pkt_valid(pkt_valid)
);

`default_nettype wire

// File: tb/ip_rx_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ip_rx_tb
  import ip_rx_pkg::*;
;

  localparam int PAYLOAD_BYTES = 4;
  localparam int GAP_CYCLES = 8;  // Longer than the three-cycle verdict to counter latency.
  localparam int NUM_FRAMES = 12;
  localparam int FRAME_CYCLES = (20 + PAYLOAD_BYTES) * (8 / STREAM_W) + GAP_CYCLES + 2;
  localparam int TIMEOUT_NS = (16 + NUM_FRAMES * FRAME_CYCLES + 600) * 40;
  localparam ipv4_addr_t LOCAL_ADDR = 32'hc0a8_0107;
  localparam ipv4_addr_t SRC_ADDR = 32'h0a00_0002;
  localparam ip_proto_t PROTO = 8'h11;
  localparam ip_len_t TOTAL_LEN = 16'd24;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic axiiv = 1'b0;
  logic [STREAM_W-1:0] axiid = '0;
  logic reg_we = 1'b0;
  reg_addr_t reg_addr = REG_LOCAL_IP;
  logic [31:0] reg_wdata = '0;
  logic [31:0] reg_rdata;
  logic pkt_valid;
  ipv4_hdr_t pkt_hdr;

  logic [7:0] hdr_bytes [0:19];
  ipv4_hdr_t last_hdr;
  int valid_cnt = 0;
  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  integer seed = 32'h7f0a;

  ip_rx_top dut0 (
    .clk(clk), .rst(rst), .axiiv(axiiv), .axiid(axiid), .reg_we(reg_we),
    .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
    .pkt_valid(pkt_valid), .pkt_hdr(pkt_hdr)
  );

  always #20 clk = ~clk;

  // Count accept pulses and keep the header seen with the last one.
  always @(posedge clk) begin
    if (!rst && pkt_valid) begin
      valid_cnt <= valid_cnt + 1;
      last_hdr <= pkt_hdr;
    end
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before)
      $display("%s: pass", name);
    else
      $display("%s: %0d errors", name, errors - err_before);
  endtask

  task automatic write_reg(input reg_addr_t addr, input logic [31:0] data);
    @(posedge clk);
    reg_we <= 1'b1;
    reg_addr <= addr;
    reg_wdata <= data;
    @(posedge clk);
    reg_we <= 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t addr, output logic [31:0] data);
    @(posedge clk);
    reg_addr <= addr;
    @(negedge clk);
    data = reg_rdata;
  endtask

  // Ones' complement of the folded sum of all header words, checksum field as zero.
  function automatic logic [15:0] header_checksum();
    logic [31:0] sum;
    int i;
    sum = '0;
    for (i = 0; i < 20; i += 2)
      if (i != 10)
        sum += {hdr_bytes[i], hdr_bytes[i+1]};
    sum = sum[15:0] + sum[31:16];
    sum = sum[15:0] + sum[31:16];
    return ~sum[15:0];
  endfunction

  task automatic build_header(input logic [3:0] ver, input logic [3:0] ihl,
                              input logic [2:0] flags, input ipv4_addr_t dst,
                              input bit corrupt);
    logic [15:0] ck;
    int k;
    hdr_bytes[0] = {ver, ihl};
    hdr_bytes[1] = 8'h00;
    hdr_bytes[2] = TOTAL_LEN[15:8];
    hdr_bytes[3] = TOTAL_LEN[7:0];
    hdr_bytes[4] = 8'h1c;
    hdr_bytes[5] = 8'h46;
    hdr_bytes[6] = {flags, 5'd0};
    hdr_bytes[7] = 8'h00;
    hdr_bytes[8] = 8'h40;  // TTL.
    hdr_bytes[9] = PROTO;
    hdr_bytes[10] = 8'h00;
    hdr_bytes[11] = 8'h00;
    for (k = 0; k < 4; k++) begin
      hdr_bytes[12+k] = SRC_ADDR[31-8*k -: 8];
      hdr_bytes[16+k] = dst[31-8*k -: 8];
    end
    ck = header_checksum();
    if (corrupt)
      ck = ck ^ 16'h0001;
    hdr_bytes[10] = ck[15:8];
    hdr_bytes[11] = ck[7:0];
  endtask

  // Sends n_bytes of the header, with payload only after a full header.
  task automatic send_frame(input int n_bytes);
    logic [7:0] b;
    int total;
    int i;
    int s;
    total = (n_bytes == 20) ? 20 + PAYLOAD_BYTES : n_bytes;
    for (i = 0; i < total; i++) begin
      b = (i < 20) ? hdr_bytes[i] : 8'($random(seed));
      for (s = 8 / STREAM_W - 1; s >= 0; s--) begin
        @(posedge clk);
        axiiv <= 1'b1;
        axiid <= b[s*STREAM_W +: STREAM_W];
      end
    end
    @(posedge clk);
    axiiv <= 1'b0;
    axiid <= '0;
    repeat (GAP_CYCLES) @(posedge clk);
  endtask

  // Sends the built header and checks pulse and counter deltas.
  task automatic frame_check(input string name, input bit accept);
    logic [31:0] acc0;
    logic [31:0] drop0;
    logic [31:0] acc1;
    logic [31:0] drop1;
    int v0;
    read_reg(REG_ACCEPT_CNT, acc0);
    read_reg(REG_DROP_CNT, drop0);
    v0 = valid_cnt;
    send_frame(20);
    read_reg(REG_ACCEPT_CNT, acc1);
    read_reg(REG_DROP_CNT, drop1);
    compare({name, " pulses"}, accept ? 1 : 0, valid_cnt - v0);
    compare({name, " accept count"}, acc0 + accept, acc1);
    compare({name, " drop count"}, drop0 + !accept, drop1);
  endtask

  task automatic test_reset_regs();
    logic [31:0] d;
    int e0;
    e0 = errors;
    read_reg(REG_LOCAL_IP, d);
    compare("reset local_ip", 32'd0, d);
    read_reg(REG_CTRL, d);
    compare("reset ctrl", 32'd1, d);
    finish_test("reset_regs", e0);
  endtask

  task automatic test_good_frame();
    logic [31:0] d;
    int e0;
    e0 = errors;
    write_reg(REG_LOCAL_IP, LOCAL_ADDR);
    build_header(4'd4, 4'd5, 3'b010, LOCAL_ADDR, 1'b0);
    frame_check("good_frame", 1'b1);
    compare("good_frame protocol", PROTO, last_hdr.protocol);
    compare("good_frame src", SRC_ADDR, last_hdr.src_ip);
    compare("good_frame dst", LOCAL_ADDR, last_hdr.dst_ip);
    compare("good_frame length", TOTAL_LEN, last_hdr.length);
    read_reg(REG_ACCEPT_CNT, d);
    compare("good_frame accept total", 32'd1, d);
    finish_test("good_frame", e0);
  endtask

  task automatic test_bad_checksum();
    int e0;
    e0 = errors;
    build_header(4'd4, 4'd5, 3'b010, LOCAL_ADDR, 1'b1);
    frame_check("bad_checksum", 1'b0);
    finish_test("bad_checksum", e0);
  endtask

  task automatic test_bad_fields();
    int e0;
    e0 = errors;
    build_header(4'd6, 4'd5, 3'b010, LOCAL_ADDR, 1'b0);
    frame_check("version_6", 1'b0);
    build_header(4'd4, 4'd6, 3'b010, LOCAL_ADDR, 1'b0);
    frame_check("ihl_6", 1'b0);
    build_header(4'd4, 4'd5, 3'b011, LOCAL_ADDR, 1'b0);
    frame_check("more_fragments", 1'b0);
    finish_test("bad_fields", e0);
  endtask

  task automatic test_dest_rule();
    int e0;
    e0 = errors;
    build_header(4'd4, 4'd5, 3'b010, 32'h0a0a_0a0a, 1'b0);
    frame_check("foreign filtered", 1'b0);
    write_reg(REG_CTRL, 32'd0);
    frame_check("foreign unfiltered", 1'b1);
    write_reg(REG_CTRL, 32'd1);
    build_header(4'd4, 4'd5, 3'b010, BCAST_ADDR, 1'b0);
    frame_check("bcast blocked", 1'b0);
    write_reg(REG_CTRL, 32'd3);
    frame_check("bcast allowed", 1'b1);
    write_reg(REG_CTRL, 32'd1);
    finish_test("dest_rule", e0);
  endtask

  task automatic test_truncated();
    logic [31:0] acc0;
    logic [31:0] drop0;
    logic [31:0] acc1;
    logic [31:0] drop1;
    int v0;
    int e0;
    e0 = errors;
    build_header(4'd4, 4'd5, 3'b010, LOCAL_ADDR, 1'b0);
    read_reg(REG_ACCEPT_CNT, acc0);
    read_reg(REG_DROP_CNT, drop0);
    v0 = valid_cnt;
    send_frame(14);  // Ends inside the source address.
    read_reg(REG_ACCEPT_CNT, acc1);
    read_reg(REG_DROP_CNT, drop1);
    compare("truncated pulses", 32'd0, valid_cnt - v0);
    compare("truncated accept count", acc0, acc1);
    compare("truncated drop count", drop0, drop1);
    frame_check("after truncated", 1'b1);
    finish_test("truncated", e0);
  endtask

  task automatic test_reg_access();
    logic [31:0] d;
    int e0;
    e0 = errors;
    write_reg(REG_LOCAL_IP, 32'hdead_beef);
    read_reg(REG_LOCAL_IP, d);
    compare("local_ip readback", 32'hdead_beef, d);
    write_reg(REG_CTRL, 32'd2);
    read_reg(REG_CTRL, d);
    compare("ctrl readback", 32'd2, d);
    write_reg(REG_CTRL, 32'd1);
    write_reg(REG_LOCAL_IP, LOCAL_ADDR);
    write_reg(REG_ACCEPT_CNT, 32'd0);
    read_reg(REG_ACCEPT_CNT, d);
    compare("accept count clear", 32'd0, d);
    write_reg(REG_DROP_CNT, 32'd0);
    read_reg(REG_DROP_CNT, d);
    compare("drop count clear", 32'd0, d);
    finish_test("reg_access", e0);
  endtask

  initial begin
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    test_reset_regs();
    test_good_frame();
    test_bad_checksum();
    test_bad_fields();
    test_dest_rule();
    test_truncated();
    test_reg_access();
    errors += dut0.asserts0.fail_cnt;  // Bound assertion failures count as errors.
    $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before the tests completed");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
common/ip_rx_pkg.sv
ipv4_rx/ones_sum_check.sv
ipv4_rx/ipv4_header_parse.sv
source/ip_dest_filter.sv
source/ip_filter_regs.sv
source/ip_rx_top.sv
tb/ip_rx_asserts.sv
tb/ip_rx_tb.sv
